// File: design/MmioPkg.sv
package MmioPkg;
	timeunit 1ns;
	timeprecision 1ps;

	// bus operation codes held at level by the requester
	typedef logic [4:0] OpmCode;

	localparam OpmCode UMEM_OPM_READY = 5'h00;
	localparam OpmCode UMEM_OPM_LDL = 5'h0A;
	localparam OpmCode UMEM_OPM_STL = 5'h12;

	// two-bit status back to the requester
	typedef logic [1:0] OkCode;

	localparam OkCode UMEM_OK_READY = 2'h0;
	localparam OkCode UMEM_OK_OK = 2'h1;
	localparam OkCode UMEM_OK_HOLD = 2'h2;
	localparam OkCode UMEM_OK_FAULT = 2'h3;

	// region tags in addr[31:16]
	localparam logic [15:0] GPIO_BASE = 16'hF000;
	localparam logic [15:0] SCRN_BASE = 16'hF00A;

	// gpio register offsets in addr[7:0]
	localparam logic [7:0] GPIO_OUT = 8'h00;
	localparam logic [7:0] GPIO_DIR = 8'h04;
	localparam logic [7:0] GPIO_IN = 8'h08;

	// screen offset bit selecting the control register over the cell area
	localparam int SCRN_CTRL_BIT = 15;

	typedef struct packed {
		logic [31:0] addr;
		OpmCode opm;
		logic [31:0] data;
	} MmioReq;

	typedef struct packed {
		logic [31:0] data;
		OkCode ok;
	} MmioResp;

	// one-hot device strobes
	typedef struct packed {
		logic gpio;
		logic scrn;
	} DevSel;

	typedef struct packed {
		logic [3:0] red;
		logic [3:0] grn;
		logic [3:0] blu;
		logic hsync;
		logic vsync;
	} VgaOut;

endpackage

// File: design/MmioBusCtl.sv
module MmioBusCtl (
	input logic clock,
	input logic reset,
	input MmioPkg::MmioReq req,
	output MmioPkg::MmioResp resp,
	output MmioPkg::DevSel sel,
	input MmioPkg::MmioResp gpioResp,
	input MmioPkg::MmioResp scrnResp
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [15:0] tag;
	logic active;
	logic gpioHit;
	logic scrnHit;
	// unmapped request seen at decode
	logic unmapped;
	// fault answer one cycle after decode like a device
	logic faultQ;

	assign tag = req.addr[31:16];
	assign active = (req.opm != MmioPkg::UMEM_OPM_READY);
	assign gpioHit = (tag == MmioPkg::GPIO_BASE);
	assign scrnHit = (tag == MmioPkg::SCRN_BASE);

	// decode stage holds the strobes for as long as opm is held
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			sel <= '0;
			unmapped <= 1'b0;
			faultQ <= 1'b0;
		end
		else
		begin
			sel.gpio <= active && gpioHit;
			sel.scrn <= active && scrnHit;
			unmapped <= active && !gpioHit && !scrnHit;
			faultQ <= active && unmapped;
		end
	end

	// fixed priority merge with gpio first
	always_comb
	begin
		resp.data = '0;
		resp.ok = MmioPkg::UMEM_OK_READY;

		if (gpioResp.ok != MmioPkg::UMEM_OK_READY)
		begin
			resp = gpioResp;
		end
		else if (scrnResp.ok != MmioPkg::UMEM_OK_READY)
		begin
			resp = scrnResp;
		end
		else if (faultQ)
		begin
			resp.ok = MmioPkg::UMEM_OK_FAULT;
		end
	end

	// never more than one device strobed
	assert property (@(posedge clock) disable iff (reset) $onehot0(sel))
	else $error("MmioBusCtl: more than one device selected");

	// an OK answer must come from a device strobed the cycle before
	assert property (@(posedge clock) disable iff (reset)
		(resp.ok == MmioPkg::UMEM_OK_OK) |-> $past($onehot(sel)))
	else $error("MmioBusCtl: OK without a single device strobe");

endmodule

// File: design/MmioGpio.sv
module MmioGpio #(
	parameter int GPIO_WIDTH = 32
) (
	input logic clock,
	input logic reset,
	input logic sel,
	input MmioPkg::MmioReq req,
	output MmioPkg::MmioResp resp,
	input logic [GPIO_WIDTH-1:0] pinsIn,
	output logic [GPIO_WIDTH-1:0] pinsOut,
	output logic [GPIO_WIDTH-1:0] pinsDir
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0] offset;
	logic active;
	logic doStore;
	// two-flop input synchronizer
	logic [GPIO_WIDTH-1:0] inMeta;
	logic [GPIO_WIDTH-1:0] inSync;
	logic [31:0] rdData;
	logic [31:0] respData;
	MmioPkg::OkCode respOk;

	// the tag is decoded upstream so only the low offset bits matter
	assign offset = req.addr[7:0];
	assign active = sel && (req.opm != MmioPkg::UMEM_OPM_READY);
	assign doStore = active && (req.opm == MmioPkg::UMEM_OPM_STL);

	always_ff @(posedge clock)
	begin
		inMeta <= pinsIn;
		inSync <= inMeta;
	end

	// output and direction registers with all pins starting as inputs
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pinsOut <= '0;
			pinsDir <= '0;
		end
		else if (doStore)
		begin
			case (offset)
				MmioPkg::GPIO_OUT: pinsOut <= req.data[GPIO_WIDTH-1:0];
				MmioPkg::GPIO_DIR: pinsDir <= req.data[GPIO_WIDTH-1:0];
				// GPIO_IN is read only so the store is dropped
				default: ;
			endcase
		end
	end

	// register read mux zero-extended to the bus word
	always_comb
	begin
		rdData = '0;
		case (offset)
			MmioPkg::GPIO_OUT: rdData[GPIO_WIDTH-1:0] = pinsOut;
			MmioPkg::GPIO_DIR: rdData[GPIO_WIDTH-1:0] = pinsDir;
			MmioPkg::GPIO_IN: rdData[GPIO_WIDTH-1:0] = inSync;
			default: rdData = '0;
		endcase
	end

	// answers in one cycle so HOLD is never needed
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			respOk <= MmioPkg::UMEM_OK_READY;
		end
		else
		begin
			respOk <= active ? MmioPkg::UMEM_OK_OK : MmioPkg::UMEM_OK_READY;
		end
	end

	always_ff @(posedge clock)
	begin
		respData <= rdData;
	end

	assign resp.data = respData;
	assign resp.ok = respOk;

	// the bus control drops the strobe in step with the answer
	assert property (@(posedge clock) disable iff (reset)
		!sel |-> (resp.ok == MmioPkg::UMEM_OK_READY))
	else $error("MmioGpio: answer while not selected");

endmodule

// File: design/MmioTxtScreen.sv
module MmioTxtScreen #(
	parameter int CELL_COLS = 8,
	parameter int CELL_ROWS = 4,
	parameter int H_ACTIVE = 64,
	parameter int H_TOTAL = 80,
	parameter int H_SYNC = 8,
	parameter int V_ACTIVE = 32,
	parameter int V_TOTAL = 40,
	parameter int V_SYNC = 2
) (
	input logic clock,
	input logic reset,
	input logic sel,
	input MmioPkg::MmioReq req,
	output MmioPkg::MmioResp resp,
	output MmioPkg::VgaOut vga
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_CELLS = CELL_COLS * CELL_ROWS;
	localparam int IDX_W = $clog2(NUM_CELLS);
	localparam int H_W = $clog2(H_TOTAL);
	localparam int V_W = $clog2(V_TOTAL);
	// active area sits at the end of each line and frame
	localparam int H_START = H_TOTAL - H_ACTIVE;
	localparam int V_START = V_TOTAL - V_ACTIVE;
	localparam MmioPkg::VgaOut VGA_IDLE = '{red: 4'h0, grn: 4'h0, blu: 4'h0,
		hsync: 1'b1, vsync: 1'b1};

	// one cell holds background, foreground and character
	typedef struct packed {
		logic [3:0] bg;
		logic [3:0] fg;
		logic [7:0] ch;
	} TxtCell;

	TxtCell cells [NUM_CELLS];
	logic enable;

	logic active;
	logic doStore;
	logic isCtrl;
	logic [IDX_W-1:0] busIdx;
	logic busIdxOk;
	logic [31:0] rdData;
	logic [31:0] respData;
	MmioPkg::OkCode respOk;

	logic [H_W-1:0] hCnt;
	logic [V_W-1:0] vCnt;
	logic [H_W-1:0] xPos;
	logic [V_W-1:0] yPos;
	logic inArea;
	logic [IDX_W-1:0] beamIdx;
	TxtCell beamCell;
	logic pixOn;
	MmioPkg::VgaOut vgaNext;

	assign active = sel && (req.opm != MmioPkg::UMEM_OPM_READY);
	assign doStore = active && (req.opm == MmioPkg::UMEM_OPM_STL);
	assign isCtrl = req.addr[MmioPkg::SCRN_CTRL_BIT];
	// word index into the cell area
	assign busIdx = req.addr[IDX_W+1:2];
	assign busIdxOk = (int'(busIdx) < NUM_CELLS);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_CELLS; i++)
			begin
				cells[i] <= '0;
			end
			enable <= 1'b1;
		end
		else if (doStore)
		begin
			if (isCtrl)
				enable <= req.data[0];
			else if (busIdxOk)
				cells[busIdx] <= req.data[15:0];
		end
	end

	always_comb
	begin
		rdData = '0;
		if (isCtrl)
			rdData[0] = enable;
		else if (busIdxOk)
			rdData[15:0] = cells[busIdx];
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			respOk <= MmioPkg::UMEM_OK_READY;
		else
			respOk <= active ? MmioPkg::UMEM_OK_OK : MmioPkg::UMEM_OK_READY;
	end

	always_ff @(posedge clock)
	begin
		respData <= rdData;
	end

	assign resp.data = respData;
	assign resp.ok = respOk;

	// pixel and line counters giving one frame per H_TOTAL * V_TOTAL clocks
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			hCnt <= '0;
			vCnt <= '0;
		end
		else if (hCnt == H_W'(H_TOTAL - 1))
		begin
			hCnt <= '0;
			vCnt <= (vCnt == V_W'(V_TOTAL - 1)) ? '0 : vCnt + 1'b1;
		end
		else
		begin
			hCnt <= hCnt + 1'b1;
		end
	end

	assign xPos = hCnt - H_W'(H_START);
	assign yPos = vCnt - V_W'(V_START);
	assign inArea = (hCnt >= H_W'(H_START)) && (vCnt >= V_W'(V_START));

	// 8x8 glyph cells with the char byte shown MSB first across the cell
	assign beamIdx = IDX_W'(int'(yPos >> 3) * CELL_COLS + int'(xPos >> 3));
	assign beamCell = cells[beamIdx];
	assign pixOn = beamCell.ch[3'd7 - xPos[2:0]];

	always_comb
	begin
		vgaNext = VGA_IDLE;
		vgaNext.hsync = (hCnt >= H_W'(H_SYNC));
		vgaNext.vsync = (vCnt >= V_W'(V_SYNC));
		if (enable && inArea)
		begin
			vgaNext.red = pixOn ? beamCell.fg : beamCell.bg;
			vgaNext.grn = pixOn ? beamCell.fg : beamCell.bg;
			vgaNext.blu = pixOn ? beamCell.fg : beamCell.bg;
		end
	end

	// colour and sync leave through the same register stage
	always_ff @(posedge clock)
	begin
		if (reset)
			vga <= VGA_IDLE;
		else
			vga <= vgaNext;
	end

	assert property (@(posedge clock) disable iff (reset) int'(hCnt) < H_TOTAL)
	else $error("MmioTxtScreen: pixel counter past line end");

endmodule

// File: design/MmioTopUnit.sv
module MmioTopUnit #(
	parameter int GPIO_WIDTH = 32,
	parameter int CELL_COLS = 8,
	parameter int CELL_ROWS = 4,
	parameter int H_ACTIVE = 64,
	parameter int H_TOTAL = 80,
	parameter int H_SYNC = 8,
	parameter int V_ACTIVE = 32,
	parameter int V_TOTAL = 40,
	parameter int V_SYNC = 2
) (
	input logic clock,
	input logic reset,
	input MmioPkg::MmioReq req,
	output MmioPkg::MmioResp resp,
	input logic [GPIO_WIDTH-1:0] gpioPinsIn,
	output logic [GPIO_WIDTH-1:0] gpioPinsOut,
	output logic [GPIO_WIDTH-1:0] gpioPinsDir,
	output MmioPkg::VgaOut vga
);
	timeunit 1ns;
	timeprecision 1ps;

	MmioPkg::DevSel sel;
	MmioPkg::MmioResp gpioResp;
	MmioPkg::MmioResp scrnResp;

	MmioBusCtl busCtl (
		.clock(clock),
		.reset(reset),
		.req(req),
		.resp(resp),
		.sel(sel),
		.gpioResp(gpioResp),
		.scrnResp(scrnResp)
	);

	MmioGpio #(
		.GPIO_WIDTH(GPIO_WIDTH)
	) gpio (
		.clock(clock),
		.reset(reset),
		.sel(sel.gpio),
		.req(req),
		.resp(gpioResp),
		.pinsIn(gpioPinsIn),
		.pinsOut(gpioPinsOut),
		.pinsDir(gpioPinsDir)
	);

	MmioTxtScreen #(
		.CELL_COLS(CELL_COLS),
		.CELL_ROWS(CELL_ROWS),
		.H_ACTIVE(H_ACTIVE),
		.H_TOTAL(H_TOTAL),
		.H_SYNC(H_SYNC),
		.V_ACTIVE(V_ACTIVE),
		.V_TOTAL(V_TOTAL),
		.V_SYNC(V_SYNC)
	) scrn (
		.clock(clock),
		.reset(reset),
		.sel(sel.scrn),
		.req(req),
		.resp(scrnResp),
		.vga(vga)
	);

endmodule

// File: tb/MmioTbTable.svh
`ifndef MMIO_TB_TABLE_SVH
`define MMIO_TB_TABLE_SVH

// what a row compares its load data against
localparam logic [1:0] CMP_NONE = 2'd0;
localparam logic [1:0] CMP_DATA = 2'd1;
// expected data is the random word driven on the input pins
localparam logic [1:0] CMP_PINS = 2'd2;

localparam MmioPkg::OpmCode LD = MmioPkg::UMEM_OPM_LDL;
localparam MmioPkg::OpmCode ST = MmioPkg::UMEM_OPM_STL;
localparam MmioPkg::OkCode OK = MmioPkg::UMEM_OK_OK;
localparam MmioPkg::OkCode FAULT = MmioPkg::UMEM_OK_FAULT;

typedef struct packed {
	logic [31:0] addr;
	MmioPkg::OpmCode opm;
	logic [31:0] wdata;
	MmioPkg::OkCode expOk;
	logic [31:0] expData;
	logic [1:0] cmp;
} TableRow;

localparam int NUM_ROWS = 17;

// address, opcode, write data, expected ok, expected data, compare
localparam TableRow STIM [NUM_ROWS] = '{
	'{32'hF000_0000, ST, 32'hA5A5_0F0F, OK, 32'h0000_0000, CMP_NONE},
	'{32'hF000_0000, LD, 32'h0000_0000, OK, 32'hA5A5_0F0F, CMP_DATA},
	'{32'hF000_0004, ST, 32'hFFFF_0000, OK, 32'h0000_0000, CMP_NONE},
	'{32'hF000_0004, LD, 32'h0000_0000, OK, 32'hFFFF_0000, CMP_DATA},
	'{32'hF000_0008, LD, 32'h0000_0000, OK, 32'h0000_0000, CMP_PINS},
	// cell 0 gets a solid glyph, white on black
	'{32'hF00A_0000, ST, 32'h0000_0FFF, OK, 32'h0000_0000, CMP_NONE},
	'{32'hF00A_0000, LD, 32'h0000_0000, OK, 32'h0000_0FFF, CMP_DATA},
	'{32'hF00A_0014, ST, 32'h0000_3C41, OK, 32'h0000_0000, CMP_NONE},
	'{32'hF00A_0014, LD, 32'h0000_0000, OK, 32'h0000_3C41, CMP_DATA},
	// last cell of the 8x4 grid
	'{32'hF00A_007C, ST, 32'h0000_A5E7, OK, 32'h0000_0000, CMP_NONE},
	'{32'hF00A_007C, LD, 32'h0000_0000, OK, 32'h0000_A5E7, CMP_DATA},
	'{32'hF00A_8000, ST, 32'h0000_0000, OK, 32'h0000_0000, CMP_NONE},
	'{32'hF00A_8000, LD, 32'h0000_0000, OK, 32'h0000_0000, CMP_DATA},
	'{32'hF00A_8000, ST, 32'h0000_0001, OK, 32'h0000_0000, CMP_NONE},
	'{32'hF00A_8000, LD, 32'h0000_0000, OK, 32'h0000_0001, CMP_DATA},
	'{32'h1234_0000, LD, 32'h0000_0000, FAULT, 32'h0000_0000, CMP_NONE},
	'{32'h1234_0010, ST, 32'hDEAD_BEEF, FAULT, 32'h0000_0000, CMP_NONE}
};

`endif

// File: tb/MmioTopUnitTb.sv
module MmioTopUnitTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int GPIO_WIDTH = 32;
	localparam int CELL_COLS = 8;
	localparam int CELL_ROWS = 4;
	localparam int H_ACTIVE = 64;
	localparam int H_TOTAL = 80;
	localparam int H_SYNC = 8;
	localparam int V_ACTIVE = 32;
	localparam int V_TOTAL = 40;
	localparam int V_SYNC = 2;
	localparam int FRAME = H_TOTAL * V_TOTAL;

	`include "MmioTbTable.svh"

	logic clock;
	logic reset;
	MmioPkg::MmioReq req;
	MmioPkg::MmioResp resp;
	logic [GPIO_WIDTH-1:0] gpioPinsIn;
	logic [GPIO_WIDTH-1:0] gpioPinsOut;
	logic [GPIO_WIDTH-1:0] gpioPinsDir;
	MmioPkg::VgaOut vga;

	integer seed;
	int testCount;
	int failCount;
	logic testBad;
	// expected state of the gpio output ports
	logic [31:0] expOut;
	logic [31:0] expDir;

	MmioTopUnit #(
		.GPIO_WIDTH(GPIO_WIDTH),
		.CELL_COLS(CELL_COLS),
		.CELL_ROWS(CELL_ROWS),
		.H_ACTIVE(H_ACTIVE),
		.H_TOTAL(H_TOTAL),
		.H_SYNC(H_SYNC),
		.V_ACTIVE(V_ACTIVE),
		.V_TOTAL(V_TOTAL),
		.V_SYNC(V_SYNC)
	) MmioTopUnit_i (
		.clock(clock),
		.reset(reset),
		.req(req),
		.resp(resp),
		.gpioPinsIn(gpioPinsIn),
		.gpioPinsOut(gpioPinsOut),
		.gpioPinsDir(gpioPinsDir),
		.vga(vga)
	);

	always
	begin
		#5 clock = ~clock;
	end

	task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] want);
		assert (got === want)
		else
		begin
			$display("error %s: got %h expected %h", name, got, want);
			testBad = 1'b1;
		end
	endtask

	task automatic reportTest(input string what);
		testCount++;
		if (testBad)
		begin
			failCount++;
			$display("test %0d %s: failed", testCount, what);
		end
		else
		begin
			$display("test %0d %s: passed", testCount, what);
		end
	endtask

	// counts rising edges until ok is idle (or busy), sampled on the falling edge
	task automatic waitStatus(input logic wantIdle, input int limit, output int cycles,
		output logic timedOut);
		logic done;
		cycles = 0;
		done = 1'b0;
		timedOut = 1'b0;
		while (!done && !timedOut)
		begin
			@(posedge clock);
			cycles++;
			@(negedge clock);
			if ((resp.ok == MmioPkg::UMEM_OK_READY) == wantIdle)
				done = 1'b1;
			else if (cycles >= limit)
				timedOut = 1'b1;
		end
	endtask

	task automatic runRow(input int n);
		TableRow row;
		int cycles;
		logic timedOut;
		logic [31:0] pinWord;
		row = STIM[n];
		testBad = 1'b0;
		if (row.cmp == CMP_PINS)
		begin
			@(posedge clock);
			pinWord = $random(seed);
			gpioPinsIn <= pinWord;
			// let the input synchronizer settle
			repeat (3) @(posedge clock);
			row.expData = pinWord;
		end
		@(posedge clock);
		req <= '{addr: row.addr, opm: row.opm, data: row.wdata};
		waitStatus(1'b0, 20, cycles, timedOut);
		if (timedOut)
		begin
			$display("row %0d: the bus gave no answer within 20 cycles", n);
			testBad = 1'b1;
		end
		else
		begin
			checkWord("latency", cycles, 2);
			checkWord("resp.ok", resp.ok, row.expOk);
			if (row.cmp != CMP_NONE)
				checkWord("resp.data", resp.data, row.expData);
		end
		if (row.opm == ST && row.addr[31:16] == MmioPkg::GPIO_BASE)
		begin
			if (row.addr[7:0] == MmioPkg::GPIO_OUT)
				expOut = row.wdata;
			else if (row.addr[7:0] == MmioPkg::GPIO_DIR)
				expDir = row.wdata;
		end
		@(posedge clock);
		req.opm <= MmioPkg::UMEM_OPM_READY;
		waitStatus(1'b1, 20, cycles, timedOut);
		if (timedOut)
		begin
			$display("row %0d: ok did not return to ready after the request ended", n);
			testBad = 1'b1;
		end
		else
		begin
			checkWord("release latency", cycles, 1);
		end
		checkWord("gpioPinsOut", gpioPinsOut, expOut);
		checkWord("gpioPinsDir", gpioPinsDir, expDir);
		reportTest($sformatf("row %0d addr %h", n, row.addr));
	endtask

	// returns at the falling edge where vsync is first seen low
	task automatic nextVsyncFall(input int limit, output int cycles, output logic timedOut);
		logic prev;
		logic found;
		cycles = 0;
		found = 1'b0;
		prev = vga.vsync;
		while (!found && cycles < limit)
		begin
			@(negedge clock);
			cycles++;
			found = prev && !vga.vsync;
			prev = vga.vsync;
		end
		timedOut = !found;
	endtask

	// one frame from the vsync fall, cycle k is pixel k % H_TOTAL of line k / H_TOTAL
	task automatic scanFrame();
		int h;
		int v;
		int badHsync;
		int lowRun;
		int badBlank;
		logic inArea;
		logic [11:0] colour;
		logic [11:0] blankVal;
		logic [11:0] firstPix;
		badHsync = 0;
		lowRun = 0;
		badBlank = 0;
		blankVal = '0;
		firstPix = '0;
		for (int k = 0; k < FRAME; k++)
		begin
			if (k > 0)
				@(negedge clock);
			h = k % H_TOTAL;
			v = k / H_TOTAL;
			inArea = (h >= H_TOTAL - H_ACTIVE) && (v >= V_TOTAL - V_ACTIVE);
			colour = {vga.red, vga.grn, vga.blu};
			if (vga.hsync !== (h >= H_SYNC))
				badHsync++;
			if (k < H_TOTAL && !vga.hsync)
				lowRun++;
			if (!inArea && colour !== 12'h000)
			begin
				if (badBlank == 0)
					blankVal = colour;
				badBlank++;
			end
			if (h == H_TOTAL - H_ACTIVE && v == V_TOTAL - V_ACTIVE)
				firstPix = colour;
		end
		checkWord("hsync low cycles", lowRun, H_SYNC);
		checkWord("hsync mismatches", badHsync, 0);
		checkWord("vga colour outside active area", blankVal, 12'h000);
		checkWord("vga colour first active pixel", firstPix, 12'hFFF);
	endtask

	initial
	begin
		int cycles;
		logic timedOut;
		clock = 1'b0;
		reset = 1'b1;
		req = '{addr: '0, opm: MmioPkg::UMEM_OPM_READY, data: '0};
		gpioPinsIn = '0;
		seed = 32'h7b65aafb;
		testCount = 0;
		failCount = 0;
		expOut = '0;
		expDir = '0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;

		for (int n = 0; n < NUM_ROWS; n++)
			runRow(n);

		testBad = 1'b0;
		nextVsyncFall(2 * FRAME, cycles, timedOut);
		if (!timedOut)
			nextVsyncFall(FRAME + 10, cycles, timedOut);
		if (timedOut)
		begin
			$display("vsync did not fall within the expected frame time");
			testBad = 1'b1;
		end
		else
		begin
			checkWord("vsync period", cycles, FRAME);
		end
		reportTest("vsync period");

		testBad = 1'b0;
		if (timedOut)
		begin
			$display("frame scan skipped, no vsync to start from");
			testBad = 1'b1;
		end
		else
		begin
			scanFrame();
		end
		reportTest("frame scan");

		$display("tests %0d, passed %0d, failed %0d", testCount, testCount - failCount,
			failCount);
		if (failCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: list.f
+incdir+tb
design/MmioPkg.sv
design/MmioBusCtl.sv
design/MmioGpio.sv
design/MmioTxtScreen.sv
design/MmioTopUnit.sv
tb/MmioTopUnitTb.sv

// File: Bender.yml
package:
  name: mmio_top_unit

sources:
  - design/MmioPkg.sv
  - design/MmioBusCtl.sv
  - design/MmioGpio.sv
  - design/MmioTxtScreen.sv
  - design/MmioTopUnit.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/MmioTopUnitTb.sv
